// ==== rtl/renkon_data_pkg.sv ====
`default_nettype none

package renkon_data_pkg;

  parameter int DWIDTH = 16;
  parameter int FRAC   = DWIDTH / 2;  // Signed 8.8 format
  parameter int KSIZE  = 5;

  // One word serves pixels, weights, bias and the feature map
  typedef logic signed [DWIDTH-1:0]   pixel_t;
  typedef logic signed [2*DWIDTH-1:0] product_t;

  // Index 0 is the top row
  typedef pixel_t [KSIZE-1:0] column_t;

  // Index is row*KSIZE + column, column 0 is the oldest
  typedef pixel_t [KSIZE*KSIZE-1:0] window_t;
  typedef pixel_t [KSIZE*KSIZE-1:0] kernel_t;

  // Drops the fraction bits of a product, rounding toward minus infinity
  function automatic pixel_t round_product(input product_t p);
    product_t shifted;
    shifted = p >>> FRAC;
    return shifted[DWIDTH-1:0];  // Keep low word, upper bits wrap away
  endfunction

endpackage

`default_nettype wire

// ==== rtl/renkon_regmap_pkg.sv ====
`default_nettype none

package renkon_regmap_pkg;

  parameter int APB_AW = 8;

  parameter logic [APB_AW-1:0] ADDR_WEIGHT0 = 8'h00;  // Weight k at +4k
  parameter logic [APB_AW-1:0] ADDR_BIAS    = 8'h64;
  parameter logic [APB_AW-1:0] ADDR_CTRL    = 8'h68;

  parameter int CTRL_RELU_BIT = 0;

endpackage

`default_nettype wire

// ==== rtl/renkon_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface renkon_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  logic     sol;    // First item of a band
  payload_t data;

  modport src (
    output valid,
    output sol,
    output data,
    input  ready
  );

  modport snk (
    input  valid,
    input  sol,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// ==== rtl/renkon_weight_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module renkon_weight_regs
  import renkon_data_pkg::*, renkon_regmap_pkg::*;
(
  input  logic              clk,
  input  logic              xrst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output kernel_t           kernel,
  output pixel_t            bias,
  output logic              relu_en
);

  logic [APB_AW-1:0] woff;
  logic [APB_AW-3:0] widx;
  logic              hit_weight;
  logic              hit_bias;
  logic              hit_ctrl;
  logic              hit;
  logic              access;
  logic              wr_en;
  logic [31:0]       rdata;

  function automatic logic [31:0] sext(input pixel_t v);
    return {{(32-DWIDTH){v[DWIDTH-1]}}, v};
  endfunction

  assign woff       = paddr - ADDR_WEIGHT0;
  assign widx       = woff[APB_AW-1:2];
  assign hit_weight = (woff[1:0] == 2'b00) && (widx < KSIZE*KSIZE);
  assign hit_bias   = (paddr == ADDR_BIAS);
  assign hit_ctrl   = (paddr == ADDR_CTRL);
  assign hit        = hit_weight || hit_bias || hit_ctrl;

  assign access = psel && penable && !pready;          // First access cycle
  assign wr_en  = psel && penable && pready && pwrite; // Completion

  always_comb begin
    rdata = '0;
    if (hit_weight) begin
      rdata = sext(kernel[widx]);
    end else if (hit_bias) begin
      rdata = sext(bias);
    end else if (hit_ctrl) begin
      rdata[CTRL_RELU_BIT] = relu_en;
    end
  end

  // One wait state, response comes with pready
  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      prdata  <= '0;
    end else begin
      pready  <= access;
      pslverr <= access && !hit;
      prdata  <= (access && !pwrite) ? rdata : '0;
    end
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      kernel  <= '0;
      bias    <= '0;
      relu_en <= 1'b0;
    end else if (wr_en) begin
      if (hit_weight) begin
        kernel[widx] <= pwdata[DWIDTH-1:0];
      end else if (hit_bias) begin
        bias <= pwdata[DWIDTH-1:0];
      end else if (hit_ctrl) begin
        relu_en <= pwdata[CTRL_RELU_BIT];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/renkon_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module renkon_window
  import renkon_data_pkg::*;
(
  input  logic         clk,
  input  logic         xrst,
  renkon_stream_if.snk col_in,
  renkon_stream_if.src win_out
);

  column_t    cols [KSIZE];
  logic [2:0] count;       // Columns held in this band, saturates at KSIZE
  logic [2:0] count_next;
  logic       win_valid;
  logic       win_sol;
  logic       take;
  window_t    win;

  assign col_in.ready = !win_valid || win_out.ready;
  assign take         = col_in.valid && col_in.ready;

  always_comb begin
    if (col_in.sol) begin
      count_next = 3'd1;  // New band
    end else if (count == 3'(KSIZE)) begin
      count_next = count;
    end else begin
      count_next = count + 3'd1;
    end
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      count     <= '0;
      win_valid <= 1'b0;
      win_sol   <= 1'b0;
    end else if (take) begin
      count     <= count_next;
      win_valid <= (count_next == 3'(KSIZE));
      win_sol   <= (count_next == 3'(KSIZE)) && (count != 3'(KSIZE));
    end else if (win_out.ready) begin
      win_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      for (int c = 0; c < KSIZE - 1; c++) begin
        cols[c] <= cols[c+1];
      end
      cols[KSIZE-1] <= col_in.data;  // Newest column on the right
    end
  end

  always_comb begin
    for (int r = 0; r < KSIZE; r++) begin
      for (int c = 0; c < KSIZE; c++) begin
        win[r*KSIZE+c] = cols[c][r];
      end
    end
  end

  assign win_out.valid = win_valid;
  assign win_out.sol   = win_sol;
  assign win_out.data  = win;

endmodule

`default_nettype wire

// ==== rtl/renkon_conv_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module renkon_conv_tree
  import renkon_data_pkg::*;
(
  input  logic         clk,
  input  logic         xrst,
  input  kernel_t      kernel,
  renkon_stream_if.snk win_in,
  renkon_stream_if.src score_out
);

  localparam int NTAP = KSIZE * KSIZE;

  window_t  r_win;
  kernel_t  r_ker;
  product_t pro       [NTAP];
  pixel_t   pro_short [NTAP];
  pixel_t   r_pro     [NTAP];
  pixel_t   sum0      [12];
  pixel_t   sum1      [6];
  pixel_t   sum2      [3];
  pixel_t   sum3      [2];
  pixel_t   sum4;
  pixel_t   r_sum;
  logic     v1;
  logic     v2;
  logic     v3;
  logic     sol1;
  logic     sol2;
  logic     sol3;
  logic     stage_en;

  // All three stages move together
  assign stage_en     = !v3 || score_out.ready;
  assign win_in.ready = stage_en;

  for (genvar i = 0; i < NTAP; i++) begin : g_mul
    assign pro[i]       = r_win[i] * r_ker[i];
    assign pro_short[i] = round_product(pro[i]);
  end

  for (genvar i = 0; i < 12; i++) begin : g_lvl0
    assign sum0[i] = r_pro[2*i] + r_pro[2*i+1];
  end

  for (genvar i = 0; i < 6; i++) begin : g_lvl1
    assign sum1[i] = sum0[2*i] + sum0[2*i+1];
  end

  for (genvar i = 0; i < 3; i++) begin : g_lvl2
    assign sum2[i] = sum1[2*i] + sum1[2*i+1];
  end

  assign sum3[0] = sum2[0] + sum2[1];
  assign sum3[1] = sum2[2] + r_pro[NTAP-1];  // Odd tap joins here
  assign sum4    = sum3[0] + sum3[1];

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      v1   <= 1'b0;
      v2   <= 1'b0;
      v3   <= 1'b0;
      sol1 <= 1'b0;
      sol2 <= 1'b0;
      sol3 <= 1'b0;
    end else if (stage_en) begin
      v1   <= win_in.valid;
      v2   <= v1;
      v3   <= v2;
      sol1 <= win_in.sol;
      sol2 <= sol1;
      sol3 <= sol2;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_en) begin
      r_win <= win_in.data;  // Stage 1
      r_ker <= kernel;
      for (int i = 0; i < NTAP; i++) begin
        r_pro[i] <= pro_short[i];  // Stage 2
      end
      r_sum <= sum4;  // Stage 3
    end
  end

  assign score_out.valid = v3;
  assign score_out.sol   = sol3;
  assign score_out.data  = r_sum;

endmodule

`default_nettype wire

// ==== rtl/renkon_bias_relu.sv ====
`timescale 1ns/1ps
`default_nettype none

module renkon_bias_relu
  import renkon_data_pkg::*;
(
  input  logic         clk,
  input  logic         xrst,
  input  pixel_t       bias,
  input  logic         relu_en,
  renkon_stream_if.snk score_in,
  renkon_stream_if.src fmap_out
);

  pixel_t biased;
  pixel_t result;
  pixel_t r_data;
  logic   r_valid;
  logic   r_sol;
  logic   adv;

  assign adv            = !r_valid || fmap_out.ready;
  assign score_in.ready = adv;

  assign biased = score_in.data + bias;  // Wraps
  assign result = (relu_en && biased[DWIDTH-1]) ? '0 : biased;

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      r_valid <= 1'b0;
      r_sol   <= 1'b0;
    end else if (adv) begin
      r_valid <= score_in.valid;
      r_sol   <= score_in.sol;
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      r_data <= result;
    end
  end

  assign fmap_out.valid = r_valid;
  assign fmap_out.sol   = r_sol;
  assign fmap_out.data  = r_data;

endmodule

`default_nettype wire

// ==== rtl/renkon_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module renkon_top
  import renkon_data_pkg::*, renkon_regmap_pkg::*;
(
  input  logic              clk,
  input  logic              xrst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              col_valid,
  input  logic              col_sol,
  input  column_t           col_data,
  output logic              col_ready,
  output logic              fmap_valid,
  output logic              fmap_sol,
  output pixel_t            fmap_data,
  input  logic              fmap_ready
);

  kernel_t kernel;
  pixel_t  bias;
  logic    relu_en;

  renkon_stream_if #(.payload_t(column_t)) col_if ();
  renkon_stream_if #(.payload_t(window_t)) win_if ();
  renkon_stream_if #(.payload_t(pixel_t))  score_if ();
  renkon_stream_if #(.payload_t(pixel_t))  fmap_if ();

  assign col_if.valid = col_valid;
  assign col_if.sol   = col_sol;
  assign col_if.data  = col_data;
  assign col_ready    = col_if.ready;

  assign fmap_valid    = fmap_if.valid;
  assign fmap_sol      = fmap_if.sol;
  assign fmap_data     = fmap_if.data;
  assign fmap_if.ready = fmap_ready;

  renkon_weight_regs u_regs (
    .clk     (clk),
    .xrst    (xrst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .kernel  (kernel),
    .bias    (bias),
    .relu_en (relu_en)
  );

  renkon_window u_window (
    .clk     (clk),
    .xrst    (xrst),
    .col_in  (col_if.snk),
    .win_out (win_if.src)
  );

  renkon_conv_tree u_tree (
    .clk       (clk),
    .xrst      (xrst),
    .kernel    (kernel),
    .win_in    (win_if.snk),
    .score_out (score_if.src)
  );

  renkon_bias_relu u_bias (
    .clk      (clk),
    .xrst     (xrst),
    .bias     (bias),
    .relu_en  (relu_en),
    .score_in (score_if.snk),
    .fmap_out (fmap_if.src)
  );

endmodule

`default_nettype wire

// ==== verification/renkon_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module renkon_tb
  import renkon_data_pkg::*, renkon_regmap_pkg::*;
();

  localparam int MAX_CYCLES = 4000;  // About 1500 cycles of tests plus margin
  localparam int LATENCY    = 5;     // Column transfer to fmap transfer
  localparam int NREGS      = KSIZE * KSIZE + 2;
  localparam int MAX_COLS   = 12;

  logic              clk;
  logic              xrst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              col_valid;
  logic              col_sol;
  column_t           col_data;
  logic              col_ready;
  logic              fmap_valid;
  logic              fmap_sol;
  pixel_t            fmap_data;
  logic              fmap_ready;

  integer      seed;
  logic [31:0] ready_rnd;
  int          cycle = 0;
  int          edge_exp;
  logic        bp_on;          // Random fmap_ready
  logic        lat_check;
  logic        expect_centre;  // Identity kernel passes the centre pixel
  kernel_t     k_model;
  pixel_t      bias_model;
  logic        relu_model;
  column_t     band [4][MAX_COLS];
  pixel_t      exp_data_q [$];
  logic        exp_sol_q [$];
  int          exp_edge_q [$];

  renkon_top u_dut (
    .clk        (clk),
    .xrst       (xrst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .col_valid  (col_valid),
    .col_sol    (col_sol),
    .col_data   (col_data),
    .col_ready  (col_ready),
    .fmap_valid (fmap_valid),
    .fmap_sol   (fmap_sol),
    .fmap_data  (fmap_data),
    .fmap_ready (fmap_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_sim();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic error_stop(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    stop_sim();
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    stop_sim();
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES)
      abort_run($sformatf("Timeout after %0d cycles, the run did not finish", MAX_CYCLES));
  end

  always @(posedge clk) begin
    #1;
    if (bp_on) begin
      ready_rnd  = $random(seed);
      fmap_ready = ready_rnd[0];
    end else begin
      fmap_ready = 1'b1;
    end
  end

  // Products shifted right by FRAC bits and cut to one word, sums wrap
  function automatic pixel_t conv_ref(input window_t w, input kernel_t k,
                                      input pixel_t b, input logic relu);
    product_t p;
    pixel_t   acc;
    acc = '0;
    for (int i = 0; i < KSIZE * KSIZE; i++) begin
      p   = w[i] * k[i];
      acc = acc + pixel_t'(p[FRAC+DWIDTH-1:FRAC]);
    end
    acc = acc + b;
    if (relu && acc[DWIDTH-1])
      acc = '0;
    return acc;
  endfunction

  task automatic check_fmap(input pixel_t got, input logic got_sol,
                            input pixel_t exp, input logic exp_sol);
    if (got !== exp)
      error_stop($sformatf("fmap data %h, expected %h", got, exp));
    else if (got_sol !== exp_sol)
      error_stop($sformatf("fmap sol %b, expected %b (data %h)", got_sol, exp_sol, got));
  endtask

  task automatic check_reg(input logic [APB_AW-1:0] addr, input logic [31:0] got,
                           input logic got_err, input logic [31:0] exp,
                           input logic exp_err, input logic data_valid);
    if (got_err !== exp_err)
      error_stop($sformatf("pslverr %b at addr %h, expected %b", got_err, addr, exp_err));
    else if (data_valid && (got !== exp))
      error_stop($sformatf("prdata %h at addr %h, expected %h", got, addr, exp));
  endtask

  function automatic logic [APB_AW-1:0] reg_addr(input int idx);
    if (idx < KSIZE * KSIZE)
      return ADDR_WEIGHT0 + APB_AW'(4 * idx);
    else if (idx == KSIZE * KSIZE)
      return ADDR_BIAS;
    return ADDR_CTRL;
  endfunction

  function automatic logic [31:0] reg_expect(input int idx);
    logic [31:0] v;
    v = '0;
    if (idx < KSIZE * KSIZE)
      v = {{(32-DWIDTH){k_model[idx][DWIDTH-1]}}, k_model[idx]};
    else if (idx == KSIZE * KSIZE)
      v = {{(32-DWIDTH){bias_model[DWIDTH-1]}}, bias_model};
    else
      v[CTRL_RELU_BIT] = relu_model;
    return v;
  endfunction

  // Setup cycle, then access until pready
  task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    do begin
      @(negedge clk);
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_reg(addr, rdata, err, 32'h0, 1'b0, 1'b0);
    if (addr == ADDR_BIAS)
      bias_model = data[DWIDTH-1:0];
    else if (addr == ADDR_CTRL)
      relu_model = data[CTRL_RELU_BIT];
    else
      k_model[(addr - ADDR_WEIGHT0) >> 2] = data[DWIDTH-1:0];
  endtask

  task automatic verify_regs();
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < NREGS; i++) begin
      apb_xfer(1'b0, reg_addr(i), 32'h0, rdata, err);
      check_reg(reg_addr(i), rdata, err, reg_expect(i), 1'b0, 1'b1);
    end
  endtask

  task automatic load_kernel(input kernel_t k);
    for (int i = 0; i < KSIZE * KSIZE; i++)
      write_reg(reg_addr(i), {16'h0, k[i]});
  endtask

  task automatic random_kernel(output kernel_t k);
    for (int i = 0; i < KSIZE * KSIZE; i++)
      k[i] = pixel_t'($random(seed));
  endtask

  task automatic fill_bands(input int nb);
    for (int b = 0; b < nb; b++)
      for (int j = 0; j < MAX_COLS; j++)
        for (int r = 0; r < KSIZE; r++)
          band[b][j][r] = pixel_t'($random(seed));
  endtask

  // Drives one band and queues the result of every completed window
  task automatic send_band(input int b, input int n, input logic gaps);
    window_t w;
    for (int j = 0; j < n; j++) begin
      if (gaps && (j % 3 == 2)) begin
        col_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      col_valid = 1'b1;
      col_sol   = (j == 0);
      col_data  = band[b][j];
      do begin
        @(negedge clk);
      end while (!col_ready);
      if (j >= KSIZE - 1) begin
        for (int r = 0; r < KSIZE; r++)
          for (int c = 0; c < KSIZE; c++)
            w[r*KSIZE+c] = band[b][j-KSIZE+1+c][r];
        if (expect_centre)
          exp_data_q.push_back(band[b][j-KSIZE/2][KSIZE/2]);
        else
          exp_data_q.push_back(conv_ref(w, k_model, bias_model, relu_model));
        exp_sol_q.push_back(j == KSIZE - 1);
        exp_edge_q.push_back(cycle + 1);  // Edge that takes the column
      end
      @(posedge clk);
      #1;
    end
    col_valid = 1'b0;
    col_sol   = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_data_q.size() != 0)
      @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic set_backpressure(input logic on);
    @(negedge clk);
    bp_on = on;
    @(posedge clk);
    #1;
  endtask

  always @(negedge clk) begin
    if (xrst && fmap_valid && fmap_ready) begin
      if (exp_data_q.size() == 0) begin
        abort_run("A feature-map word arrived while no window result was expected");
      end else begin
        edge_exp = exp_edge_q.pop_front();
        check_fmap(fmap_data, fmap_sol, exp_data_q.pop_front(), exp_sol_q.pop_front());
        if (lat_check && (cycle + 1 - edge_exp != LATENCY))
          error_stop($sformatf("fmap after %0d cycles, expected %0d",
                               cycle + 1 - edge_exp, LATENCY));
      end
    end
  end

  initial begin
    logic [31:0]       rdata;
    logic              err;
    kernel_t           k;
    logic [APB_AW-1:0] bad_addr [4];
    seed          = 32'h8b56_49f8;
    xrst          = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    col_valid     = 1'b0;
    col_sol       = 1'b0;
    col_data      = '0;
    fmap_ready    = 1'b1;
    bp_on         = 1'b0;
    lat_check     = 1'b1;
    expect_centre = 1'b0;
    k_model       = '0;
    bias_model    = '0;
    relu_model    = 1'b0;
    bad_addr      = '{8'h6c, 8'h02, 8'h80, 8'hfc};
    repeat (2) @(posedge clk);
    #1;
    xrst = 1'b1;
    if (fmap_valid !== 1'b0 || pready !== 1'b0 || pslverr !== 1'b0)
      abort_run("Outputs were active right after reset");

    verify_regs();  // Reset values
    for (int i = 0; i < NREGS; i++)
      write_reg(reg_addr(i), $random(seed));
    verify_regs();
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b1, bad_addr[i], $random(seed), rdata, err);
      check_reg(bad_addr[i], rdata, err, 32'h0, 1'b1, 1'b0);
      apb_xfer(1'b0, bad_addr[i], 32'h0, rdata, err);
      check_reg(bad_addr[i], rdata, err, 32'h0, 1'b1, 1'b0);
    end
    verify_regs();  // Unmapped writes change nothing

    k     = '0;
    k[12] = 16'h0100;  // 1.0 on the centre tap
    load_kernel(k);
    write_reg(ADDR_BIAS, 32'h0);
    write_reg(ADDR_CTRL, 32'h0);
    fill_bands(2);
    expect_centre = 1'b1;
    send_band(0, MAX_COLS, 1'b0);
    send_band(1, MAX_COLS, 1'b0);
    wait_idle();
    expect_centre = 1'b0;

    repeat (3) begin
      random_kernel(k);
      load_kernel(k);
      write_reg(ADDR_BIAS, $random(seed));
      fill_bands(2);
      send_band(0, MAX_COLS, 1'b0);
      send_band(1, MAX_COLS, 1'b0);
      wait_idle();
    end

    random_kernel(k);
    load_kernel(k);
    write_reg(ADDR_BIAS, 32'hffff_fc00);  // Bias of -4.0
    fill_bands(2);
    for (int relu = 0; relu < 2; relu++) begin
      write_reg(ADDR_CTRL, 32'(relu));
      send_band(0, MAX_COLS, 1'b0);
      send_band(1, MAX_COLS, 1'b0);
      wait_idle();
    end

    fill_bands(4);
    lat_check = 1'b0;
    set_backpressure(1'b1);
    for (int b = 0; b < 4; b++)
      send_band(b, MAX_COLS, 1'b1);
    wait_idle();
    set_backpressure(1'b0);
    lat_check = 1'b1;

    send_band(0, 5, 1'b0);
    send_band(1, 4, 1'b0);  // Too short for a window
    send_band(2, 9, 1'b0);
    send_band(3, MAX_COLS, 1'b0);
    send_band(1, 7, 1'b0);
    wait_idle();
    repeat (2 * LATENCY) @(posedge clk);  // Drain time for any extra word

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== renkon.f ====
rtl/renkon_data_pkg.sv
rtl/renkon_regmap_pkg.sv
rtl/renkon_stream_if.sv
rtl/renkon_weight_regs.sv
rtl/renkon_window.sv
rtl/renkon_conv_tree.sv
rtl/renkon_bias_relu.sv
rtl/renkon_top.sv
verification/renkon_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module renkon_tb \
  -f renkon.f -Mdir obj_dir -o renkon_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/renkon_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
